// ==== sources.f ====
hdl/dcache_pkg.sv
hdl/access_align.sv
hdl/write_buffer.sv
hdl/wb_drain.sv
hdl/data_mem.sv
hdl/load_unit.sv
hdl/dcache_store_top.sv
test/tb_dcache_store.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f sources.f --top-module tb_dcache_store -o sim_dcache_store
./obj_dir/sim_dcache_store | tee sim.log

if grep -q "test failed" sim.log; then
    exit 1
fi

// ==== test/tb_dcache_store.sv ====
`timescale 1ns/1ps

module tb_dcache_store
    import dcache_pkg::*;
;

    // about 300 cycles of traffic, the limit leaves ten times that
    localparam int unsigned MAX_CYCLES = 3000;

    typedef struct packed {
        word_t       data;
        byte_addr_t  addr;
        logic [31:0] due;
    } load_exp_t;

    logic         clk_i;
    logic         rstn_i;
    logic         req_valid_i;
    logic         req_store_i;
    access_size_e req_size_i;
    byte_addr_t   req_addr_i;
    word_t        req_wdata_i;
    logic         req_ready_o;
    logic         load_valid_o;
    word_t        load_data_o;
    logic         wb_empty_o;

    word_t        ref_mem [64];
    load_exp_t    exp_q [$];
    load_exp_t    mon_exp;
    logic [31:0]  cycle_cnt = 0;
    integer       seed = 96;
    int           error_cnt;
    int           tests_run;
    int           tests_ok;
    logic         ready_low_seen;

    dcache_store_top u_dcache_store_top (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .req_valid_i  (req_valid_i),
        .req_store_i  (req_store_i),
        .req_size_i   (req_size_i),
        .req_addr_i   (req_addr_i),
        .req_wdata_i  (req_wdata_i),
        .req_ready_o  (req_ready_o),
        .load_valid_o (load_valid_o),
        .load_data_o  (load_data_o),
        .wb_empty_o   (wb_empty_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin
        wait (cycle_cnt == MAX_CYCLES);
        $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("test failed");
        $finish;
    end

    function automatic int unsigned size_bytes(input access_size_e size);
        case (size)
            SIZE_BYTE: return 1;
            SIZE_HALF: return 2;
            default:   return 4;
        endcase
    endfunction

    // reference model, lanes counted up from the byte offset
    task automatic ref_store(input access_size_e size, input byte_addr_t addr, input word_t wdata);
        int unsigned off;
        off = 32'(addr[1:0]);
        for (int unsigned b = 0; b < size_bytes(size); b++) begin
            ref_mem[addr[7:2]][8*(off+b) +: 8] = wdata[8*b +: 8];
        end
    endtask

    function automatic word_t ref_load(input access_size_e size, input byte_addr_t addr);
        word_t       res;
        int unsigned off;
        res = '0;
        off = 32'(addr[1:0]);
        for (int unsigned b = 0; b < size_bytes(size); b++) begin
            res[8*b +: 8] = ref_mem[addr[7:2]][8*(off+b) +: 8];
        end
        return res;
    endfunction

    task automatic compare_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("error at %0t ns: %s got %h expected %h", $time, what, got, exp);
            error_cnt++;
        end
    endtask

    task automatic compare_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("error at %0t ns: %s got %b expected %b", $time, what, got, exp);
            error_cnt++;
        end
    endtask

    // every load result must land exactly at its due cycle, in order
    always @(negedge clk_i) begin
        if (load_valid_o === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("load_valid_o came without an accepted load at %0t ns", $time);
                error_cnt++;
            end else begin
                mon_exp = exp_q.pop_front();
                if (mon_exp.due != cycle_cnt) begin
                    $display("load result for %h arrived at cycle %0d, due at cycle %0d",
                             mon_exp.addr, cycle_cnt, mon_exp.due);
                    error_cnt++;
                end
                compare_word(load_data_o, mon_exp.data,
                             $sformatf("load data at %h", mon_exp.addr));
            end
        end else if (exp_q.size() != 0 && exp_q[0].due <= cycle_cnt) begin
            mon_exp = exp_q.pop_front();
            $display("load result for %h never arrived (due at cycle %0d)",
                     mon_exp.addr, mon_exp.due);
            error_cnt++;
        end
    end

    // called at a rising edge, returns at the edge that accepts the request
    task automatic issue_request(input logic store, input access_size_e size,
                                 input byte_addr_t addr, input word_t wdata);
        logic        taken;
        logic [31:0] acc_cycle;
        load_exp_t   e;
        req_valid_i <= 1'b1;
        req_store_i <= store;
        req_size_i  <= size;
        req_addr_i  <= addr;
        req_wdata_i <= wdata;
        taken = 1'b0;
        acc_cycle = '0;
        while (!taken) begin
            @(negedge clk_i);
            taken = req_ready_o;
            if (!taken) begin
                ready_low_seen = 1'b1;
            end
            acc_cycle = cycle_cnt;
            @(posedge clk_i);
        end
        if (store) begin
            ref_store(size, addr, wdata);
        end else begin
            e.data = ref_load(size, addr);
            e.addr = addr;
            e.due  = acc_cycle + 2;
            exp_q.push_back(e);
        end
    endtask

    task automatic end_request();
        req_valid_i <= 1'b0;
    endtask

    task automatic wait_loads_done();
        end_request();
        while (exp_q.size() != 0) begin
            @(posedge clk_i);
        end
    endtask

    task automatic wait_buffer_empty();
        end_request();
        // the last store reaches the buffer one edge after acceptance
        @(posedge clk_i);
        @(negedge clk_i);
        while (wb_empty_o !== 1'b1) begin
            @(negedge clk_i);
        end
        @(posedge clk_i);
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (error_cnt == errs_before) begin
            tests_ok++;
            $display("%s: ok", name);
        end else begin
            $display("%s: FAIL, %0d errors", name, error_cnt - errs_before);
        end
    endtask

    task automatic check_reset_state();
        int errs;
        errs = error_cnt;
        @(negedge clk_i);
        compare_flag(req_ready_o, 1'b1, "req_ready_o after reset");
        compare_flag(load_valid_o, 1'b0, "load_valid_o after reset");
        compare_flag(wb_empty_o, 1'b1, "wb_empty_o after reset");
        @(posedge clk_i);
        issue_request(1'b0, SIZE_WORD, 16'd20, '0);
        wait_loads_done();
        report_test("reset_state", errs);
    endtask

    task automatic check_forwarding();
        int    errs;
        word_t d1;
        word_t d2;
        errs = error_cnt;
        d1 = $random(seed);
        d2 = $random(seed);
        issue_request(1'b1, SIZE_WORD, 16'd40, d1);
        issue_request(1'b0, SIZE_WORD, 16'd40, '0);
        end_request();
        @(negedge clk_i);
        compare_flag(wb_empty_o, 1'b0, "wb_empty_o with a store buffered");
        @(posedge clk_i);
        // byte out of the upper half of a buffered word
        issue_request(1'b1, SIZE_WORD, 16'd44, d2);
        issue_request(1'b0, SIZE_BYTE, 16'd46, '0);
        wait_loads_done();
        report_test("forwarding", errs);
    endtask

    task automatic check_drain_merge();
        int         errs;
        byte_addr_t base;
        errs = error_cnt;
        for (int w = 0; w < 3; w++) begin
            issue_request(1'b1, SIZE_WORD, byte_addr_t'(80 + 4*w), $random(seed));
        end
        issue_request(1'b1, SIZE_BYTE, 16'd81, $random(seed));
        issue_request(1'b1, SIZE_HALF, 16'd86, $random(seed));
        issue_request(1'b1, SIZE_BYTE, 16'd91, $random(seed));
        wait_buffer_empty();
        for (int w = 0; w < 3; w++) begin
            base = byte_addr_t'(80 + 4*w);
            issue_request(1'b0, SIZE_WORD, base, '0);
            for (int b = 0; b < 4; b++) begin
                issue_request(1'b0, SIZE_BYTE, base + byte_addr_t'(b), '0);
            end
            issue_request(1'b0, SIZE_HALF, base, '0);
            issue_request(1'b0, SIZE_HALF, base + 16'd2, '0);
        end
        wait_loads_done();
        report_test("drain_merge", errs);
    endtask

    task automatic check_back_pressure();
        int errs;
        errs = error_cnt;
        ready_low_seen = 1'b0;
        for (int w = 0; w < 8; w++) begin
            issue_request(1'b1, SIZE_WORD, byte_addr_t'(128 + 4*w), $random(seed));
        end
        compare_flag(ready_low_seen, 1'b1, "req_ready_o dropped during store burst");
        wait_buffer_empty();
        for (int w = 0; w < 8; w++) begin
            issue_request(1'b0, SIZE_WORD, byte_addr_t'(128 + 4*w), '0);
        end
        wait_loads_done();
        report_test("back_pressure", errs);
    endtask

    task automatic check_pipelined_loads();
        int           errs;
        int unsigned  pick;
        int unsigned  word_idx;
        int unsigned  off;
        access_size_e size;
        errs = error_cnt;
        // full-word stores, so any load of these words is fully covered
        for (int w = 0; w < 3; w++) begin
            issue_request(1'b1, SIZE_WORD, byte_addr_t'(192 + 4*w), $random(seed));
        end
        for (int n = 0; n < 16; n++) begin
            pick = {$random(seed)} % 14;
            if (pick < 3) begin
                word_idx = 48 + pick;
            end else if (pick < 6) begin
                word_idx = 20 + pick - 3;
            end else begin
                word_idx = 32 + pick - 6;
            end
            case ({$random(seed)} % 3)
                0: begin
                    size = SIZE_BYTE;
                    off  = {$random(seed)} % 4;
                end
                1: begin
                    size = SIZE_HALF;
                    off  = ({$random(seed)} % 2) * 2;
                end
                default: begin
                    size = SIZE_WORD;
                    off  = 0;
                end
            endcase
            issue_request(1'b0, size, byte_addr_t'(4*word_idx + off), '0);
        end
        wait_loads_done();
        report_test("pipelined_loads", errs);
    endtask

    initial begin
        rstn_i      <= 1'b0;
        req_valid_i <= 1'b0;
        req_store_i <= 1'b0;
        req_size_i  <= SIZE_WORD;
        req_addr_i  <= '0;
        req_wdata_i <= '0;
        error_cnt = 0;
        tests_run = 0;
        tests_ok  = 0;
        ready_low_seen = 1'b0;
        for (int i = 0; i < 64; i++) begin
            ref_mem[i] = '0;
        end
        repeat (2) @(posedge clk_i);
        rstn_i <= 1'b1;

        check_reset_state();
        check_forwarding();
        check_drain_merge();
        check_back_pressure();
        check_pipelined_loads();

        // let a stray late result show up
        repeat (4) @(posedge clk_i);
        $display("summary: %0d tests, %0d ok, %0d failing, %0d errors",
                 tests_run, tests_ok, tests_run - tests_ok, error_cnt);
        if (error_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== hdl/dcache_store_top.sv ====
`timescale 1ns/1ps

module dcache_store_top
    import dcache_pkg::*;
#(
    parameter int unsigned DEPTH_LOG2 = 2,
    parameter int unsigned DRAIN_GAP  = 3,
    parameter int unsigned MEM_AW     = 6
) (
    input  logic         clk_i,
    input  logic         rstn_i,
    input  logic         req_valid_i,
    input  logic         req_store_i,
    input  access_size_e req_size_i,
    input  byte_addr_t   req_addr_i,
    input  word_t        req_wdata_i,
    output logic         req_ready_o,
    output logic         load_valid_o,
    output word_t        load_data_o,
    output logic         wb_empty_o
);

    aligned_req_t req;
    wb_entry_t    store_entry;
    wb_entry_t    wb_rdata;
    logic         store_we;
    logic         load_re;
    logic         wb_full;
    logic         wb_pop;
    logic         wb_hit;
    word_t        wb_hit_data;
    logic         mem_we;
    word_addr_t   mem_addr;
    sel_t         mem_be;
    word_t        mem_wdata;
    word_t        mem_rdata;

    assign store_entry = '{data: req.data, sel: req.sel, addr: req.addr};

    access_align u_access_align (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .req_valid_i (req_valid_i),
        .req_store_i (req_store_i),
        .req_size_i  (req_size_i),
        .req_addr_i  (req_addr_i),
        .req_wdata_i (req_wdata_i),
        .wb_full_i   (wb_full),
        .req_ready_o (req_ready_o),
        .req_o       (req),
        .store_we_o  (store_we),
        .load_re_o   (load_re)
    );

    write_buffer #(
        .DEPTH_LOG2 (DEPTH_LOG2)
    ) u_write_buffer (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .we_i            (store_we),
        .entry_i         (store_entry),
        .re_i            (wb_pop),
        .check_i         (load_re),
        .check_address_i (req.addr),
        .check_sel_i     (req.sel),
        .rdata_o         (wb_rdata),
        .empty_o         (wb_empty_o),
        .full_o          (wb_full),
        .hit_o           (wb_hit),
        .hit_data_o      (wb_hit_data)
    );

    wb_drain #(
        .DRAIN_GAP (DRAIN_GAP)
    ) u_wb_drain (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .empty_i     (wb_empty_o),
        .entry_i     (wb_rdata),
        .pop_o       (wb_pop),
        .mem_we_o    (mem_we),
        .mem_addr_o  (mem_addr),
        .mem_be_o    (mem_be),
        .mem_wdata_o (mem_wdata)
    );

    // memory is indexed by the low word address bits
    data_mem #(
        .MEM_AW (MEM_AW)
    ) u_data_mem (
        .clk_i   (clk_i),
        .we_i    (mem_we),
        .waddr_i (mem_addr[MEM_AW-1:0]),
        .be_i    (mem_be),
        .wdata_i (mem_wdata),
        .re_i    (load_re),
        .raddr_i (req.addr[MEM_AW-1:0]),
        .rdata_o (mem_rdata)
    );

    load_unit u_load_unit (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .load_re_i    (load_re),
        .size_i       (req.size),
        .offset_i     (req.offset),
        .hit_i        (wb_hit),
        .hit_data_i   (wb_hit_data),
        .mem_rdata_i  (mem_rdata),
        .load_valid_o (load_valid_o),
        .load_data_o  (load_data_o)
    );

endmodule

// ==== hdl/load_unit.sv ====
`timescale 1ns/1ps

module load_unit
    import dcache_pkg::*;
(
    input  logic         clk_i,
    input  logic         rstn_i,
    input  logic         load_re_i,
    input  access_size_e size_i,
    input  logic [1:0]   offset_i,
    input  logic         hit_i,
    input  word_t        hit_data_i,
    input  word_t        mem_rdata_i,
    output logic         load_valid_o,
    output word_t        load_data_o
);

    logic         valid_q;
    access_size_e size_q;
    logic [1:0]   offset_q;
    word_t        word_sel;
    word_t        word_shifted;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= load_re_i;
        end
    end

    // size and offset line up with hit and memory data
    always_ff @(posedge clk_i) begin
        size_q   <= size_i;
        offset_q <= offset_i;
    end

    // forwarded data takes priority over memory
    assign word_sel     = hit_i ? hit_data_i : mem_rdata_i;
    assign word_shifted = word_sel >> {offset_q, 3'b000};

    always_comb begin
        case (size_q)
            SIZE_BYTE: load_data_o = {24'b0, word_shifted[7:0]};
            SIZE_HALF: load_data_o = {16'b0, word_shifted[15:0]};
            default:   load_data_o = word_shifted;
        endcase
    end

    assign load_valid_o = valid_q;

endmodule

// ==== hdl/data_mem.sv ====
`timescale 1ns/1ps

module data_mem
    import dcache_pkg::*;
#(
    parameter int unsigned MEM_AW = 6
) (
    input  logic              clk_i,
    input  logic              we_i,
    input  logic [MEM_AW-1:0] waddr_i,
    input  sel_t              be_i,
    input  word_t             wdata_i,
    input  logic              re_i,
    input  logic [MEM_AW-1:0] raddr_i,
    output word_t             rdata_o
);

    word_t mem [2 ** MEM_AW];
    word_t rdata_q;

    // memory powers up cleared
    initial begin
        for (int i = 0; i < 2 ** MEM_AW; i++) begin
            mem[i] = '0;
        end
    end

    // byte enabled write
    always_ff @(posedge clk_i) begin
        for (int b = 0; b < 4; b++) begin
            if (we_i && be_i[b]) begin
                mem[waddr_i][8*b +: 8] <= wdata_i[8*b +: 8];
            end
        end
    end

    // read returns the old word when it collides with a write
    always_ff @(posedge clk_i) begin
        if (re_i) begin
            rdata_q <= mem[raddr_i];
        end
    end

    assign rdata_o = rdata_q;

endmodule

// ==== hdl/wb_drain.sv ====
`timescale 1ns/1ps

module wb_drain
    import dcache_pkg::*;
#(
    parameter int unsigned DRAIN_GAP = 3
) (
    input  logic       clk_i,
    input  logic       rstn_i,
    input  logic       empty_i,
    input  wb_entry_t  entry_i,
    output logic       pop_o,
    output logic       mem_we_o,
    output word_addr_t mem_addr_o,
    output sel_t       mem_be_o,
    output word_t      mem_wdata_o
);

    localparam int unsigned CNT_W = (DRAIN_GAP > 1) ? $clog2(DRAIN_GAP) : 1;

    drain_state_e     state_q;
    logic [CNT_W-1:0] gap_cnt_q;

    // pop and memory write share the same edge
    assign pop_o       = (state_q == ST_IDLE) && !empty_i;
    assign mem_we_o    = pop_o;
    assign mem_addr_o  = entry_i.addr;
    assign mem_be_o    = entry_i.sel;
    assign mem_wdata_o = entry_i.data;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q   <= ST_IDLE;
            gap_cnt_q <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (pop_o) begin
                        state_q   <= ST_GAP;
                        gap_cnt_q <= '0;
                    end
                end
                ST_GAP: begin
                    // wait DRAIN_GAP cycles before the next pop
                    if (gap_cnt_q == CNT_W'(DRAIN_GAP - 1)) begin
                        state_q <= ST_IDLE;
                    end else begin
                        gap_cnt_q <= gap_cnt_q + 1'b1;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

endmodule

// ==== hdl/write_buffer.sv ====
`timescale 1ns/1ps

module write_buffer
    import dcache_pkg::*;
#(
    parameter int unsigned DEPTH_LOG2 = 2
) (
    input  logic       clk_i,
    input  logic       rstn_i,
    input  logic       we_i,
    input  wb_entry_t  entry_i,
    input  logic       re_i,
    input  logic       check_i,
    input  word_addr_t check_address_i,
    input  sel_t       check_sel_i,
    output wb_entry_t  rdata_o,
    output logic       empty_o,
    output logic       full_o,
    output logic       hit_o,
    output word_t      hit_data_o
);

    localparam int unsigned NUM_ELEMS = 2 ** DEPTH_LOG2;

    wb_entry_t entries [NUM_ELEMS];

    // top bit of each pointer flags a wrap
    logic [DEPTH_LOG2:0]   wr_ptr;
    logic [DEPTH_LOG2:0]   rd_ptr;
    logic [DEPTH_LOG2-1:0] wr_idx;
    logic [DEPTH_LOG2-1:0] rd_idx;
    logic                  we;
    logic                  re;
    logic [NUM_ELEMS-1:0]  valid_d;
    logic [NUM_ELEMS-1:0]  valid_q;
    logic [NUM_ELEMS-1:0]  line_hit;
    logic [DEPTH_LOG2-1:0] hit_idx;
    logic                  hit_d;
    logic                  hit_q;
    word_t                 hit_data_q;

    assign wr_idx = wr_ptr[DEPTH_LOG2-1:0];
    assign rd_idx = rd_ptr[DEPTH_LOG2-1:0];

    assign empty_o = (wr_ptr == rd_ptr);
    assign full_o  = (wr_ptr[DEPTH_LOG2] != rd_ptr[DEPTH_LOG2]) && (wr_idx == rd_idx);

    // requests that cannot be served are dropped
    assign we = we_i & ~full_o;
    assign re = re_i & ~empty_o;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (we) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (re) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (we) begin
            entries[wr_idx] <= entry_i;
        end
    end

    // head entry, no read latency
    assign rdata_o = entries[rd_idx];

    always_comb begin
        valid_d = valid_q;
        if (we) begin
            valid_d[wr_idx] = 1'b1;
        end
        if (re) begin
            valid_d[rd_idx] = 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_d;
        end
    end

    // an entry matches when its lanes cover every requested lane
    always_comb begin
        for (int i = 0; i < NUM_ELEMS; i++) begin
            line_hit[i] = valid_q[i] &&
                          (entries[i].addr == check_address_i) &&
                          ((entries[i].sel & check_sel_i) == check_sel_i);
        end
    end

    // lowest matching index wins
    always_comb begin
        hit_idx = '0;
        for (int i = NUM_ELEMS - 1; i >= 0; i--) begin
            if (line_hit[i]) begin
                hit_idx = i[DEPTH_LOG2-1:0];
            end
        end
    end

    assign hit_d = |line_hit;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            hit_q <= 1'b0;
        end else begin
            hit_q <= hit_d;
        end
    end

    // data register only loads on a check
    always_ff @(posedge clk_i) begin
        if (check_i) begin
            hit_data_q <= entries[hit_idx].data;
        end
    end

    assign hit_o      = hit_q;
    assign hit_data_o = hit_data_q;

endmodule

// ==== hdl/access_align.sv ====
`timescale 1ns/1ps

module access_align
    import dcache_pkg::*;
(
    input  logic         clk_i,
    input  logic         rstn_i,
    input  logic         req_valid_i,
    input  logic         req_store_i,
    input  access_size_e req_size_i,
    input  byte_addr_t   req_addr_i,
    input  word_t        req_wdata_i,
    input  logic         wb_full_i,
    output logic         req_ready_o,
    output aligned_req_t req_o,
    output logic         store_we_o,
    output logic         load_re_o
);

    aligned_req_t req_d;
    aligned_req_t req_q;
    logic         valid_q;
    logic         hold;
    logic [1:0]   offset;
    sel_t         sel_base;
    word_t        data_masked;

    assign offset = req_addr_i[1:0];

    always_comb begin
        case (req_size_i)
            SIZE_BYTE: begin
                sel_base    = 4'b0001;
                data_masked = {24'b0, req_wdata_i[7:0]};
            end
            SIZE_HALF: begin
                sel_base    = 4'b0011;
                data_masked = {16'b0, req_wdata_i[15:0]};
            end
            default: begin
                sel_base    = 4'b1111;
                data_masked = req_wdata_i;
            end
        endcase

        req_d.is_store = req_store_i;
        req_d.size     = req_size_i;
        req_d.offset   = offset;
        req_d.addr     = req_addr_i[15:2];
        // move select and data up into the addressed lanes
        req_d.sel      = sel_base << offset;
        req_d.data     = data_masked << {offset, 3'b000};
    end

    // a store stays in the register until the buffer has room
    assign hold        = valid_q & req_q.is_store & wb_full_i;
    assign req_ready_o = ~hold;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            valid_q <= 1'b0;
        end else if (!hold) begin
            valid_q <= req_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!hold && req_valid_i) begin
            req_q <= req_d;
        end
    end

    assign req_o      = req_q;
    assign store_we_o = valid_q & req_q.is_store & ~wb_full_i;
    // loads leave the register after one cycle
    assign load_re_o  = valid_q & ~req_q.is_store;

endmodule

// ==== hdl/dcache_pkg.sv ====
package dcache_pkg;

    // address and data widths
    typedef logic [15:0] byte_addr_t;
    typedef logic [13:0] word_addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  sel_t;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } access_size_e;

    // request after alignment, data already sits in its byte lanes
    typedef struct packed {
        logic         is_store;
        access_size_e size;
        logic [1:0]   offset;
        word_addr_t   addr;
        sel_t         sel;
        word_t        data;
    } aligned_req_t;

    // one write buffer line
    typedef struct packed {
        word_t      data;
        sel_t       sel;
        word_addr_t addr;
    } wb_entry_t;

    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_GAP  = 1'b1
    } drain_state_e;

endpackage
